// File: verilog/mips_pkg.sv
package mips_pkg;

	typedef logic [31:0] word_t;    // Data or address word
	typedef logic [4:0]  reg_idx_t; // Register number
	typedef logic [5:0]  opcode_t;  // Primary opcode field
	typedef logic [5:0]  funct_t;   // R-type function field
	typedef logic [3:0]  alu_op_t;  // ALU operation select

	// Primary opcodes
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_J     = 6'b000010;
	localparam opcode_t OP_JAL   = 6'b000011;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BNE   = 6'b000101;
	localparam opcode_t OP_ADDIU = 6'b001001;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_SLTIU = 6'b001011;
	localparam opcode_t OP_ANDI  = 6'b001100;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LUI   = 6'b001111;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_SW    = 6'b101011;

	// R-type function codes
	localparam funct_t FN_SLL  = 6'b000000;
	localparam funct_t FN_SRL  = 6'b000010;
	localparam funct_t FN_SRA  = 6'b000011;
	localparam funct_t FN_JR   = 6'b001000;
	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_AND  = 6'b100100;
	localparam funct_t FN_OR   = 6'b100101;
	localparam funct_t FN_XOR  = 6'b100110;
	localparam funct_t FN_SLT  = 6'b101010;
	localparam funct_t FN_SLTU = 6'b101011;

	// ALU operations
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_AND  = 4'd2;
	localparam alu_op_t ALU_OR   = 4'd3;
	localparam alu_op_t ALU_XOR  = 4'd4;
	localparam alu_op_t ALU_SLT  = 4'd5;
	localparam alu_op_t ALU_SLTU = 4'd6;
	localparam alu_op_t ALU_SLL  = 4'd7;
	localparam alu_op_t ALU_SRL  = 4'd8;
	localparam alu_op_t ALU_SRA  = 4'd9;
	localparam alu_op_t ALU_LUI  = 4'd10;

endpackage

// File: verilog/mips_alu.sv
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
	input  alu_op_t  alu_op,
	input  word_t    a,      // rs value
	input  word_t    b,      // rt value or immediate
	input  reg_idx_t shamt,  // Shift amount field
	output word_t    result,
	output logic     zero    // a equals b
);

	word_t sum;
	word_t diff;
	logic  lt_signed;
	logic  lt_unsigned;

	assign sum  = a + b;
	assign diff = a - b; // Shared by SUB and the branch compare

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	// Branch equality from the subtraction
	assign zero = (diff == '0);

	always_comb begin
		case (alu_op)
			ALU_ADD: begin
				result = sum;
			end
			ALU_SUB: begin
				result = diff;
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_SLT: begin
				result = {31'b0, lt_signed}; // Signed compare
			end
			ALU_SLTU: begin
				result = {31'b0, lt_unsigned};
			end
			ALU_SLL: begin
				result = b << shamt; // Shifts act on rt
			end
			ALU_SRL: begin
				result = b >> shamt;
			end
			ALU_SRA: begin
				result = word_t'($signed(b) >>> shamt); // Keeps the sign
			end
			ALU_LUI: begin
				result = {b[15:0], 16'b0}; // Immediate to upper half
			end
			default: begin
				result = sum;
			end
		endcase
	end

endmodule

// File: verilog/mips_regfile.sv
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*; (
	input  logic     clk,
	input  logic     we,  // Already gated by the datapath
	input  reg_idx_t ra1,
	input  reg_idx_t ra2,
	input  reg_idx_t wa,
	input  word_t    wd,
	output word_t    rd1,
	output word_t    rd2,
	output word_t    v0   // Register 2
);

	word_t regs [32];

	// Clocked write, r0 never written
	always_ff @(posedge clk) begin
		if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// Combinational reads, r0 reads zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

	assign v0 = regs[2];

endmodule

// File: verilog/mips_decoder.sv
`timescale 1ns/1ps

module mips_decoder import mips_pkg::*; (
	input  word_t   instr,        // Current instruction
	input  logic    zero,         // ALU equality flag
	output logic    reg_write,    // Register file write
	output logic    reg_dst,      // Write rd rather than rt
	output logic    link,         // Write pc+4 into r31
	output logic    alu_src_imm,  // Immediate as operand B
	output logic    imm_zero_ext, // Zero-extend immediate
	output logic    mem_to_reg,   // Write back loaded data
	output logic    mem_write,
	output logic    mem_read,
	output logic    pc_branch,    // Branch taken
	output logic    jump,         // J or JAL target
	output logic    jump_reg,     // JR target
	output alu_op_t alu_op
);

	opcode_t opcode;
	funct_t  funct;
	logic    branch;    // BEQ
	logic    branch_ne; // BNE

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// Taken when the compare agrees with the branch sense
	assign pc_branch = (branch & zero) | (branch_ne & ~zero);

	// Main decoder
	always_comb begin
		reg_write    = 1'b0; // Default is a no-op
		reg_dst      = 1'b0;
		link         = 1'b0;
		alu_src_imm  = 1'b0;
		imm_zero_ext = 1'b0;
		mem_to_reg   = 1'b0;
		mem_write    = 1'b0;
		mem_read     = 1'b0;
		branch       = 1'b0;
		branch_ne    = 1'b0;
		jump         = 1'b0;
		jump_reg     = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				reg_dst = 1'b1;
				case (funct)
					FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
					FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA: reg_write = 1'b1;
					FN_JR:   jump_reg = 1'b1; // No link
					default: ;                // Unknown funct, no-op
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_LUI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1; // Sign-extended immediate
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				reg_write    = 1'b1;
				alu_src_imm  = 1'b1;
				imm_zero_ext = 1'b1; // Logical ops zero-extend
			end
			OP_LW: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1; // Base plus offset
				mem_to_reg  = 1'b1;
				mem_read    = 1'b1;
			end
			OP_SW: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
			end
			OP_BEQ:  branch    = 1'b1; // Compare rs and rt
			OP_BNE:  branch_ne = 1'b1;
			OP_J:    jump      = 1'b1;
			OP_JAL: begin
				jump      = 1'b1;
				link      = 1'b1; // Return address into r31
				reg_write = 1'b1;
			end
			default: ; // Unsupported opcode
		endcase
	end

	// ALU decoder
	always_comb begin
		alu_op = ALU_ADD; // Loads, stores, ADDIU
		case (opcode)
			OP_RTYPE: begin
				case (funct)
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_SLL:  alu_op = ALU_SLL;
					FN_SRL:  alu_op = ALU_SRL;
					FN_SRA:  alu_op = ALU_SRA;
					default: alu_op = ALU_ADD; // ADDU and JR
				endcase
			end
			OP_BEQ, OP_BNE: alu_op = ALU_SUB; // Zero flag compare
			OP_SLTI:        alu_op = ALU_SLT;
			OP_SLTIU:       alu_op = ALU_SLTU;
			OP_ANDI:        alu_op = ALU_AND;
			OP_ORI:         alu_op = ALU_OR;
			OP_XORI:        alu_op = ALU_XOR;
			OP_LUI:         alu_op = ALU_LUI;
			default:        alu_op = ALU_ADD;
		endcase
	end

endmodule

// File: verilog/mips_datapath.sv
`timescale 1ns/1ps

module mips_datapath import mips_pkg::*; #(
	parameter word_t RESET_VECTOR = 32'hBFC00000
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    clk_enable,
	input  logic    reg_write,
	input  logic    reg_dst,
	input  logic    link,
	input  logic    alu_src_imm,
	input  logic    imm_zero_ext,
	input  logic    mem_to_reg,
	input  logic    mem_write,
	input  logic    mem_read,
	input  logic    pc_branch,
	input  logic    jump,
	input  logic    jump_reg,
	input  alu_op_t alu_op,
	input  word_t   instr,
	input  word_t   data_readdata,
	output logic    zero,
	output logic    active,
	output word_t   register_v0,
	output word_t   pc,
	output word_t   data_address,
	output word_t   data_writedata,
	output logic    data_write,
	output logic    data_read
);

	localparam reg_idx_t LINK_REG = 5'd31;

	reg_idx_t    rs, rt, rd, wa;
	word_t       rd1, rd2, v0;
	word_t       src_a, src_b;
	word_t       imm_ext, alu_result, wb_data;
	word_t       pc_plus4, branch_target, jump_target, pc_next;
	logic [31:0] written; // Registers written since reset
	logic        step;    // Instruction retires this edge
	logic        reg_we;
	logic        halt;

	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	assign step   = clk_enable & active;
	assign reg_we = reg_write & step;

	mips_regfile u_regfile (.clk(clk), .we(reg_we), .ra1(rs), .ra2(rt), .wa(wa),
		.wd(wb_data), .rd1(rd1), .rd2(rd2), .v0(v0));

	// Unwritten registers read zero, so each run after reset starts clean
	assign src_a       = written[rs] ? rd1 : '0;
	assign data_writedata = written[rt] ? rd2 : '0; // Store data and rt operand
	assign register_v0 = written[2] ? v0 : '0;

	// Immediate extension
	assign imm_ext = imm_zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign src_b   = alu_src_imm ? imm_ext : data_writedata;

	mips_alu u_alu (.alu_op(alu_op), .a(src_a), .b(src_b), .shamt(instr[10:6]),
		.result(alu_result), .zero(zero));

	assign data_address = alu_result; // Effective address for LW and SW
	assign data_write   = mem_write & step; // No write on stall or after halt
	assign data_read    = mem_read & active;

	// Write-back destination and value
	assign wa      = link ? LINK_REG : (reg_dst ? rd : rt);
	assign wb_data = link ? pc_plus4 : (mem_to_reg ? data_readdata : alu_result);

	// Next PC, no delay slot
	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00}; // Always sign-extended here
	assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};
	always_comb begin
		if (jump_reg) pc_next = src_a;
		else if (jump) pc_next = jump_target;
		else if (pc_branch) pc_next = branch_target;
		else pc_next = pc_plus4;
	end

	assign halt = jump_reg & (src_a == '0); // JR to address 0 ends the run

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc      <= RESET_VECTOR;
			active  <= 1'b1;
			written <= '0;
		end else if (step) begin
			pc <= pc_next; // Holds once inactive
			if (halt) active <= 1'b0;
			if (reg_write && (wa != '0)) written[wa] <= 1'b1;
		end
	end

endmodule

// File: verilog/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; #(
	parameter word_t RESET_VECTOR = 32'hBFC00000 // First fetch address
) (
	input  logic  clk,
	input  logic  reset,
	output logic  active,         // Low once halted
	output word_t register_v0,
	input  logic  clk_enable,     // Low stalls the core
	output word_t instr_address,
	input  word_t instr_readdata, // Combinational fetch
	output word_t data_address,
	output logic  data_write,
	output logic  data_read,
	output word_t data_writedata,
	input  word_t data_readdata   // Combinational load
);

	logic    reg_write, reg_dst, link, alu_src_imm, imm_zero_ext;
	logic    mem_to_reg, mem_write, mem_read;
	logic    pc_branch, jump, jump_reg;
	logic    zero;
	alu_op_t alu_op;

	mips_decoder u_decoder (
		.instr(instr_readdata), .zero(zero),
		.reg_write(reg_write), .reg_dst(reg_dst), .link(link),
		.alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
		.mem_to_reg(mem_to_reg), .mem_write(mem_write), .mem_read(mem_read),
		.pc_branch(pc_branch), .jump(jump), .jump_reg(jump_reg),
		.alu_op(alu_op)
	);

	mips_datapath #(.RESET_VECTOR(RESET_VECTOR)) u_datapath (
		.clk(clk), .reset(reset), .clk_enable(clk_enable),
		.reg_write(reg_write), .reg_dst(reg_dst), .link(link),
		.alu_src_imm(alu_src_imm), .imm_zero_ext(imm_zero_ext),
		.mem_to_reg(mem_to_reg), .mem_write(mem_write), .mem_read(mem_read),
		.pc_branch(pc_branch), .jump(jump), .jump_reg(jump_reg),
		.alu_op(alu_op),
		.instr(instr_readdata), .data_readdata(data_readdata),
		.zero(zero), .active(active), .register_v0(register_v0),
		.pc(instr_address), // PC drives the fetch port
		.data_address(data_address), .data_writedata(data_writedata),
		.data_write(data_write), .data_read(data_read)
	);

endmodule

// File: dv/mips_ref_model.svh
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

localparam int    IMEM_WORDS = 256;
localparam int    DMEM_WORDS = 64;
localparam word_t DATA_BASE  = 32'h1000_0000; // Window reached by LW and SW through r28

word_t imem [IMEM_WORDS];       // Program, shared by DUT side and model
word_t dut_dmem [DMEM_WORDS];   // Data memory behind the DUT ports
word_t model_dmem [DMEM_WORDS];
word_t model_regs [32];
word_t exp_pc_q [$];            // Fetch address after each retire
logic  exp_rd_q [$];            // Load retired at each step
word_t exp_st_addr_q [$];
word_t exp_st_data_q [$];
int    model_store_count;
word_t model_v0;

// Every address bit reaches the pattern
function automatic word_t fill_word(input word_t addr);
	return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_0F1E;
endfunction

function automatic word_t enc_r(input funct_t fn, input reg_idx_t rs, rt, rd, sh);
	return {OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic word_t enc_i(input opcode_t op, input reg_idx_t rs, rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// Sources: preamble regs, data base r28, link reg r31
function automatic reg_idx_t pick_src();
	int unsigned r;
	r = $urandom % 18;
	if (r < 16) return reg_idx_t'(r);
	else if (r == 16) return 5'd28;
	else return 5'd31;
endfunction

function automatic reg_idx_t pick_dst();
	return reg_idx_t'(2 + $urandom % 14); // r2..r15, r28 stays the data base
endfunction

function automatic void write_reg(input reg_idx_t r, input word_t v);
	if (r != 0) model_regs[r] = v;
endfunction

task automatic generate_program(input word_t base);
	funct_t   alu_fns [10] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR,
		FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
	opcode_t  imm_ops [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	int       last, tgt;
	funct_t   fn;
	opcode_t  op;
	reg_idx_t sh;
	for (int i = 0; i < IMEM_WORDS; i++) imem[i] = '0; // NOP fill
	for (int k = 2; k < 16; k++) begin
		imem[2 * k - 4] = enc_i(OP_LUI, 5'd0, reg_idx_t'(k), 16'($urandom));
		imem[2 * k - 3] = enc_i(OP_ORI, reg_idx_t'(k), reg_idx_t'(k), 16'($urandom));
	end
	imem[28] = enc_i(OP_LUI, 5'd0, 5'd28, DATA_BASE[31:16]);
	last = 29 + 60 + int'($urandom % 60); // Index of the final JR
	for (int idx = 29; idx < last; idx++) begin
		tgt = idx + 1 + int'($urandom % 8); // Forward only
		if (tgt > last) tgt = last;
		case (int'($urandom % 10))
			0, 1, 2, 3: begin
				fn = alu_fns[$urandom % 10];
				if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) sh = reg_idx_t'($urandom);
				else sh = 5'd0;
				imem[idx] = enc_r(fn, pick_src(), pick_src(), pick_dst(), sh);
			end
			4, 5: begin
				op = imm_ops[$urandom % 7];
				imem[idx] = enc_i(op, (op == OP_LUI) ? 5'd0 : pick_src(), pick_dst(), 16'($urandom));
			end
			6: imem[idx] = enc_i(OP_LW, 5'd28, pick_dst(), {8'd0, 6'($urandom), 2'b00});
			7: imem[idx] = enc_i(OP_SW, 5'd28, pick_src(), {8'd0, 6'($urandom), 2'b00});
			8: begin
				op = ($urandom % 2 == 0) ? OP_BEQ : OP_BNE;
				imem[idx] = enc_i(op, pick_src(), pick_src(), 16'(tgt - idx - 1));
			end
			default: begin
				op = ($urandom % 2 == 0) ? OP_J : OP_JAL;
				imem[idx] = {op, 26'((base + word_t'(4 * tgt)) >> 2)};
			end
		endcase
	end
	imem[last] = enc_r(FN_JR, 5'd0, 5'd0, 5'd0, 5'd0); // Halt
endtask

// ISA-level execution of imem, no delay slot
task automatic run_model(input word_t base);
	word_t    pc, ins, a, b, sx, nxt, off;
	reg_idx_t rs, rt, rd;
	int       steps;
	logic     done;
	for (int i = 0; i < 32; i++) model_regs[i] = '0;
	for (int i = 0; i < DMEM_WORDS; i++) model_dmem[i] = fill_word(DATA_BASE + word_t'(4 * i));
	exp_pc_q.delete();
	exp_rd_q.delete();
	exp_st_addr_q.delete();
	exp_st_data_q.delete();
	model_store_count = 0;
	pc = base;
	done = 1'b0;
	steps = 0;
	while (!done && steps < IMEM_WORDS) begin
		off = pc - base;
		ins = imem[off[9:2]];
		rs = ins[25:21];
		rt = ins[20:16];
		rd = ins[15:11];
		a = model_regs[rs];
		b = model_regs[rt];
		sx = {{16{ins[15]}}, ins[15:0]};
		nxt = pc + 32'd4;
		case (opcode_t'(ins[31:26]))
			OP_RTYPE: case (funct_t'(ins[5:0]))
				FN_ADDU: write_reg(rd, a + b);
				FN_SUBU: write_reg(rd, a - b);
				FN_AND:  write_reg(rd, a & b);
				FN_OR:   write_reg(rd, a | b);
				FN_XOR:  write_reg(rd, a ^ b);
				FN_SLT:  write_reg(rd, {31'b0, $signed(a) < $signed(b)});
				FN_SLTU: write_reg(rd, {31'b0, a < b});
				FN_SLL:  write_reg(rd, b << ins[10:6]);
				FN_SRL:  write_reg(rd, b >> ins[10:6]);
				FN_SRA:  write_reg(rd, word_t'($signed(b) >>> ins[10:6]));
				FN_JR: begin
					nxt = a;
					done = (a == '0); // JR to 0 ends the program
				end
				default: ;
			endcase
			OP_ADDIU: write_reg(rt, a + sx);
			OP_SLTI:  write_reg(rt, {31'b0, $signed(a) < $signed(sx)});
			OP_SLTIU: write_reg(rt, {31'b0, a < sx});
			OP_ANDI:  write_reg(rt, a & {16'b0, ins[15:0]});
			OP_ORI:   write_reg(rt, a | {16'b0, ins[15:0]});
			OP_XORI:  write_reg(rt, a ^ {16'b0, ins[15:0]});
			OP_LUI:   write_reg(rt, {ins[15:0], 16'b0});
			OP_LW: begin
				off = a + sx - DATA_BASE;
				write_reg(rt, model_dmem[off[7:2]]);
			end
			OP_SW: begin
				off = a + sx - DATA_BASE;
				model_dmem[off[7:2]] = b;
				exp_st_addr_q.push_back(a + sx);
				exp_st_data_q.push_back(b);
				model_store_count++;
			end
			OP_BEQ: if (a == b) nxt = pc + 32'd4 + {sx[29:0], 2'b00};
			OP_BNE: if (a != b) nxt = pc + 32'd4 + {sx[29:0], 2'b00};
			OP_J:   nxt = {nxt[31:28], ins[25:0], 2'b00};
			OP_JAL: begin
				write_reg(5'd31, pc + 32'd4); // Link past the jump
				nxt = {nxt[31:28], ins[25:0], 2'b00};
			end
			default: ;
		endcase
		exp_rd_q.push_back(opcode_t'(ins[31:26]) == OP_LW);
		exp_pc_q.push_back(nxt);
		pc = nxt;
		steps++;
	end
	model_v0 = model_regs[2];
endtask

`endif

// File: dv/mips_cpu_harvard_tb.sv
`timescale 1ns/1ps

module mips_cpu_harvard_tb import mips_pkg::*; ();

	localparam word_t RESET_VECTOR = 32'hBFC0_0000;
	localparam int    HALT_TIMEOUT = 5000; // Enabled or stalled cycles per program
	localparam int    NUM_PROGRAMS = 3;

	logic  clk, reset, clk_enable;
	word_t instr_readdata, data_readdata;
	logic  active, data_write, data_read;
	word_t register_v0, instr_address, data_address, data_writedata;
	int    store_count; // Stores seen at the DUT port

	`include "mips_ref_model.svh"

	mips_cpu_harvard #(.RESET_VECTOR(RESET_VECTOR)) dut (
		.clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
		.clk_enable(clk_enable), .instr_address(instr_address),
		.instr_readdata(instr_readdata), .data_address(data_address),
		.data_write(data_write), .data_read(data_read),
		.data_writedata(data_writedata), .data_readdata(data_readdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			report_failure($sformatf("MISMATCH time=%0t %s got=%08h expected=%08h",
				$time, name, got, exp));
		end
	endtask

	function automatic word_t fetch_word(input word_t addr);
		word_t off;
		off = addr - RESET_VECTOR;
		if (off < word_t'(4 * IMEM_WORDS) && addr[1:0] == 2'b00) return imem[off[9:2]];
		return '0; // NOP outside the program
	endfunction

	function automatic word_t load_word(input word_t addr);
		word_t off;
		off = addr - DATA_BASE;
		if (off < word_t'(4 * DMEM_WORDS) && addr[1:0] == 2'b00) return dut_dmem[off[7:2]];
		return fill_word(addr);
	endfunction

	// Fetch first, data address settles from the new instruction
	task automatic drive_memories();
		instr_readdata = fetch_word(instr_address);
		#1;
		data_readdata = load_word(data_address);
		#0.5;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		clk_enable = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		drive_memories();
		check_value("instr_address", instr_address, RESET_VECTOR);
		check_value("active", word_t'(active), 32'd1);
		check_value("data_write", word_t'(data_write), 32'd0);
		check_value("data_read", word_t'(data_read), 32'd0);
		check_value("register_v0", register_v0, 32'd0);
	endtask

	// One clock, inputs on the falling edge, outputs sampled away from edges
	task automatic step_cycle(input logic en);
		word_t pre_pc, pre_v0, wr_addr, wr_data, off;
		logic  pre_act, wr, rd;
		@(negedge clk);
		clk_enable = en;
		drive_memories();
		pre_pc  = instr_address;
		pre_v0  = register_v0;
		pre_act = active;
		wr      = data_write;
		rd      = data_read;
		wr_addr = data_address;
		wr_data = data_writedata;
		@(posedge clk);
		#0.5;
		if (wr) begin
			if (exp_st_addr_q.size() == 0) report_failure("Store seen after the last expected store");
			check_value("data_address", wr_addr, exp_st_addr_q.pop_front());
			check_value("data_writedata", wr_data, exp_st_data_q.pop_front());
			off = wr_addr - DATA_BASE;
			dut_dmem[off[7:2]] = wr_data; // Memory takes the write at this edge
			store_count++;
		end
		if (en && pre_act) begin
			if (exp_pc_q.size() == 0) report_failure("Core retired past the end of the program");
			check_value("instr_address", instr_address, exp_pc_q.pop_front());
			check_value("data_read", word_t'(rd), word_t'(exp_rd_q.pop_front()));
			check_value("active", word_t'(active), word_t'(exp_pc_q.size() != 0));
		end else begin
			check_value("instr_address", instr_address, pre_pc); // Stall or halted
			check_value("register_v0", register_v0, pre_v0);
			check_value("data_write", word_t'(wr), 32'd0);
		end
	endtask

	task automatic run_program(input int prog);
		int cycles;
		generate_program(RESET_VECTOR);
		run_model(RESET_VECTOR);
		for (int i = 0; i < DMEM_WORDS; i++) dut_dmem[i] = fill_word(DATA_BASE + word_t'(4 * i));
		store_count = 0;
		apply_reset();
		cycles = 0;
		while (active) begin
			if (cycles == HALT_TIMEOUT) begin
				report_failure($sformatf("Program %0d: core never halted within %0d cycles",
					prog, HALT_TIMEOUT));
			end
			step_cycle($urandom % 4 != 0); // About a quarter stalled
			cycles++;
		end
		check_value("fetches left", word_t'(exp_pc_q.size()), 32'd0);
		repeat (20) begin
			step_cycle($urandom % 4 != 0);
			check_value("active", word_t'(active), 32'd0);
		end
		check_value("register_v0", register_v0, model_v0);
		check_value("store count", word_t'(store_count), word_t'(model_store_count));
	endtask

	initial begin
		int unsigned seed_val;
		reset = 1'b1;
		clk_enable = 1'b0;
		instr_readdata = '0;
		data_readdata = '0;
		seed_val = $urandom(32'h03b5_aabf);
		for (int p = 0; p < NUM_PROGRAMS; p++) run_program(p);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: mips_cpu_harvard.f
+incdir+dv
verilog/mips_pkg.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_decoder.sv
verilog/mips_datapath.sv
verilog/mips_cpu_harvard.sv
dv/mips_cpu_harvard_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MIPS core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mips_cpu_harvard.f \
	--top-module mips_cpu_harvard_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vmips_cpu_harvard_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
